/* cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// ==========================================================================
// cache geometry
// ==========================================================================

`define CACHE_ADDR_BITS      16   // word address width
`define CACHE_DATA_BITS      32   // one data word

`define CACHE_INDEX_BITS     4    // selects one of the lines
`define CACHE_OFFSET_BITS    2    // word within a line

`define CACHE_NUM_LINES      16   // 2**index bits
`define CACHE_WORDS_PER_LINE 4    // 2**offset bits

// whatever is left of the address above index and offset
`define CACHE_TAG_BITS       10

`endif

/* cache_pkg.sv */
`include "cache_defs.svh"

package cache_pkg;

  // ==========================================================================
  // address and data types
  // ==========================================================================

  typedef logic [`CACHE_ADDR_BITS-1:0]   addr_t;    // word address
  typedef logic [`CACHE_DATA_BITS-1:0]   word_t;    // data word

  typedef logic [`CACHE_TAG_BITS-1:0]    tag_t;     // upper address bits
  typedef logic [`CACHE_INDEX_BITS-1:0]  index_t;   // line number
  typedef logic [`CACHE_OFFSET_BITS-1:0] offset_t;  // word in line

  // one tag store entry as read out for a lookup
  typedef struct packed {
    logic valid;  // line holds data
    logic dirty;  // line differs from main memory
    tag_t tag;    // address bits of the cached line
  } tag_entry_t;

endpackage

/* cache_ifs.sv */
`timescale 1ns/1ps

// ==========================================================================
// controller to tag store
// ==========================================================================

interface tag_port_if;
  import cache_pkg::*;

  index_t index;         // line to read or write
  tag_t   lookup_tag;    // compared against the stored tag
  logic   rd_en;         // start a lookup
  logic   wr_en;         // write the whole entry
  tag_t   wr_tag;
  logic   wr_valid;
  logic   wr_dirty;
  logic   clear_dirty;   // drop only the dirty bit of index
  logic   hit;           // valid and tags equal, one cycle after rd_en
  logic   victim_dirty;  // the line must be written back before reuse
  tag_t   victim_tag;    // tag of the line currently held

  modport ctrl (output index, lookup_tag, rd_en, wr_en, wr_tag, wr_valid, wr_dirty,
                output clear_dirty, input hit, victim_dirty, victim_tag);
  modport store (input index, lookup_tag, rd_en, wr_en, wr_tag, wr_valid, wr_dirty,
                 input clear_dirty, output hit, victim_dirty, victim_tag);
endinterface

// ==========================================================================
// controller to data store
// ==========================================================================

interface data_port_if;
  import cache_pkg::*;

  index_t  index;   // line
  offset_t offset;  // word in line
  logic    rd_en;   // rdata valid on the next cycle
  logic    wr_en;
  word_t   wdata;
  word_t   rdata;   // holds until the next rd_en

  modport ctrl (output index, offset, rd_en, wr_en, wdata, input rdata);
  modport store (input index, offset, rd_en, wr_en, wdata, output rdata);
endinterface

/* tag_store.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module tag_store (
  input logic       clk,
  input logic       reset,
  tag_port_if.store tp
);
  import cache_pkg::*;

  localparam int NUM_LINES = `CACHE_NUM_LINES;

  tag_t                 tag_mem [NUM_LINES];  // tag per line
  logic [NUM_LINES-1:0] valid_bits;           // one per line
  logic [NUM_LINES-1:0] dirty_bits;
  tag_entry_t           rd_entry;             // entry captured by the last lookup
  tag_t                 rd_lookup;            // tag that lookup asked for

  // valid and dirty flags, cleared on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (tp.wr_en) begin
      valid_bits[tp.index] <= tp.wr_valid;
      dirty_bits[tp.index] <= tp.wr_dirty;
    end else if (tp.clear_dirty) begin
      dirty_bits[tp.index] <= 1'b0;          // line written back, data kept
    end
  end

  always_ff @(posedge clk) begin
    if (tp.wr_en) begin
      tag_mem[tp.index] <= tp.wr_tag;
    end
  end

  // ==========================================================================
  // lookup, one cycle
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (tp.rd_en) begin
      rd_entry.valid <= valid_bits[tp.index];
      rd_entry.dirty <= dirty_bits[tp.index];
      rd_entry.tag   <= tag_mem[tp.index];
      rd_lookup      <= tp.lookup_tag;
    end
  end

  assign tp.hit          = rd_entry.valid && (rd_entry.tag == rd_lookup);
  assign tp.victim_dirty = rd_entry.valid && rd_entry.dirty;  // only valid lines spill
  assign tp.victim_tag   = rd_entry.tag;                      // write-back address upper part

endmodule

/* data_store.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module data_store (
  input logic        clk,
  data_port_if.store dp
);
  import cache_pkg::*;

  localparam int NUM_WORDS = `CACHE_NUM_LINES * `CACHE_WORDS_PER_LINE;
  localparam int WADDR_BITS = $clog2(NUM_WORDS);

  word_t                 word_mem [NUM_WORDS];  // all lines, word by word
  logic [WADDR_BITS-1:0] word_addr;             // flat word index

  assign word_addr = {dp.index, dp.offset};    // line major, offset minor

  // write lands at the edge, visible to a read on the next cycle
  always_ff @(posedge clk) begin
    if (dp.wr_en) begin
      word_mem[word_addr] <= dp.wdata;
    end
  end

  // registered read, rdata keeps its value between reads
  always_ff @(posedge clk) begin
    if (dp.rd_en) begin
      dp.rdata <= word_mem[word_addr];
    end
  end

endmodule

/* cache_ctrl.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module cache_ctrl (
  input  logic              clk,
  input  logic              reset,
  input  logic              flush,
  output logic              flush_done,
  input  logic              req_val,
  input  logic              req_write,
  input  cache_pkg::addr_t  req_addr,
  input  cache_pkg::word_t  req_wdata,
  output logic              req_rdy,
  output logic              resp_val,
  input  logic              resp_rdy,
  output cache_pkg::word_t  resp_rdata,
  output logic              mem_req_val,
  output logic              mem_req_write,
  output cache_pkg::addr_t  mem_req_addr,
  output cache_pkg::word_t  mem_req_wdata,
  input  logic              mem_req_rdy,
  input  logic              mem_resp_val,
  output logic              mem_resp_rdy,
  input  cache_pkg::word_t  mem_resp_rdata,
  tag_port_if.ctrl          tp,
  data_port_if.ctrl         dp
);
  import cache_pkg::*;

  localparam int OFF_BITS = `CACHE_OFFSET_BITS;
  localparam int IDX_BITS = `CACHE_INDEX_BITS;
  localparam int TAG_BITS = `CACHE_TAG_BITS;
  localparam int ADDR_BITS = `CACHE_ADDR_BITS;
  localparam logic [OFF_BITS:0] WORDS_CNT = `CACHE_WORDS_PER_LINE;
  localparam index_t LAST_LINE = index_t'(`CACHE_NUM_LINES - 1);

  typedef enum logic [2:0] {
    ST_IDLE,    // waiting for a request or flush
    ST_LOOKUP,  // store outputs valid, hit answers here
    ST_EV_RD,   // fetch word 0 of the victim
    ST_EV_WR,   // send victim words to memory
    ST_REFILL,  // four reads out, four responses in
    ST_REPLAY,  // look the request up again after refill
    ST_FL_RD,   // flush lookup of line fl_idx
    ST_FL_CHK   // dirty lines go to write-back
  } state_t;

  state_t            state;
  logic              req_write_q;   // accepted request
  addr_t             req_addr_q;
  word_t             req_wdata_q;
  logic              fl_mode;       // evict belongs to a flush walk
  index_t            fl_idx;        // line under flush
  offset_t           wb_cnt;        // write-back words sent
  logic [OFF_BITS:0] rf_sent;       // refill reads sent
  logic [OFF_BITS:0] rf_recv;       // refill responses taken

  tag_t    in_tag, req_tag;
  index_t  in_index, req_index, cur_index;
  offset_t in_offset, req_offset;
  logic    accept, fl_start, fl_adv, fl_last;
  logic    wr_hit, wb_fire, wb_last, rf_fire, rf_recv_fire, rf_last;

  // address fields of the incoming and of the held request
  assign in_tag     = req_addr[ADDR_BITS-1 -: TAG_BITS];
  assign in_index   = req_addr[OFF_BITS +: IDX_BITS];
  assign in_offset  = req_addr[OFF_BITS-1:0];
  assign req_tag    = req_addr_q[ADDR_BITS-1 -: TAG_BITS];
  assign req_index  = req_addr_q[OFF_BITS +: IDX_BITS];
  assign req_offset = req_addr_q[OFF_BITS-1:0];
  assign cur_index  = fl_mode ? fl_idx : req_index;  // line being evicted or refilled

  assign req_rdy      = (state == ST_IDLE) && !flush;
  assign accept       = req_val && req_rdy;
  assign fl_start     = (state == ST_IDLE) && flush && !flush_done;
  assign wr_hit       = (state == ST_LOOKUP) && tp.hit && req_write_q && resp_rdy;
  assign wb_fire      = (state == ST_EV_WR) && mem_req_rdy;
  assign wb_last      = wb_fire && (wb_cnt == offset_t'(WORDS_CNT - 1'b1));
  assign rf_fire      = (state == ST_REFILL) && mem_req_val && mem_req_rdy;
  assign rf_recv_fire = (state == ST_REFILL) && mem_resp_val;
  assign rf_last      = rf_recv_fire && (rf_recv == WORDS_CNT - 1'b1);
  assign fl_last      = (fl_idx == LAST_LINE);
  // a flushed line is finished when clean or after its fourth write
  assign fl_adv = ((state == ST_FL_CHK) && !tp.victim_dirty) || (wb_last && fl_mode);

  // ==========================================================================
  // store ports
  // ==========================================================================

  always_comb begin
    tp.index       = cur_index;
    tp.lookup_tag  = req_tag;
    tp.rd_en       = 1'b0;
    tp.wr_en       = 1'b0;
    tp.wr_tag      = req_tag;
    tp.wr_valid    = 1'b1;
    tp.wr_dirty    = wr_hit;                 // refill installs a clean line
    tp.clear_dirty = 1'b0;
    dp.index       = cur_index;
    dp.offset      = req_offset;
    dp.rd_en       = 1'b0;
    dp.wr_en       = 1'b0;
    dp.wdata       = req_wdata_q;
    case (state)
      ST_IDLE: begin
        tp.index      = in_index;            // look up straight from the port
        tp.lookup_tag = in_tag;
        tp.rd_en      = accept;
        dp.index      = in_index;
        dp.offset     = in_offset;
        dp.rd_en      = accept;
      end
      ST_LOOKUP: begin
        tp.wr_en = wr_hit;                   // write hit marks the line dirty
        dp.wr_en = wr_hit;
      end
      ST_EV_RD, ST_FL_RD: begin
        tp.rd_en  = (state == ST_FL_RD);
        dp.offset = '0;
        dp.rd_en  = 1'b1;
      end
      ST_EV_WR: begin
        dp.offset      = wb_cnt + offset_t'(1);  // prefetch the next word
        dp.rd_en       = wb_fire && !wb_last;
        tp.clear_dirty = wb_last && fl_mode;
      end
      ST_REFILL: begin
        dp.offset = rf_recv[OFF_BITS-1:0];   // responses come back in order
        dp.wr_en  = rf_recv_fire;
        dp.wdata  = mem_resp_rdata;
        tp.wr_en  = rf_last;
      end
      ST_REPLAY: begin
        tp.rd_en = 1'b1;
        dp.rd_en = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // ==========================================================================
  // processor and memory sides
  // ==========================================================================

  assign resp_val   = (state == ST_LOOKUP) && tp.hit;
  assign resp_rdata = req_write_q ? '0 : dp.rdata;  // writes answer with zero

  assign mem_req_val   = (state == ST_EV_WR) || ((state == ST_REFILL) && (rf_sent != WORDS_CNT));
  assign mem_req_write = (state == ST_EV_WR);
  assign mem_req_addr  = (state == ST_EV_WR) ? {tp.victim_tag, cur_index, wb_cnt}
                                             : {req_tag, req_index, rf_sent[OFF_BITS-1:0]};
  assign mem_req_wdata = dp.rdata;           // victim word read the cycle before
  assign mem_resp_rdy  = (state == ST_REFILL);

  always_ff @(posedge clk) begin
    if (accept) begin
      req_write_q <= req_write;
      req_addr_q  <= req_addr;
      req_wdata_q <= req_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ST_IDLE;
      fl_mode    <= 1'b0;
      fl_idx     <= '0;
      wb_cnt     <= '0;
      rf_sent    <= '0;
      rf_recv    <= '0;
      flush_done <= 1'b0;
    end else begin
      if (!flush) flush_done <= 1'b0;        // done drops one cycle after flush
      if (state != ST_EV_WR) wb_cnt <= '0;
      if (state != ST_REFILL) begin
        rf_sent <= '0;
        rf_recv <= '0;
      end
      case (state)
        ST_IDLE: begin
          if (fl_start) begin
            fl_mode <= 1'b1;
            fl_idx  <= '0;
            state   <= ST_FL_RD;
          end else if (accept) begin
            state <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (tp.hit) begin
            if (resp_rdy) state <= ST_IDLE;  // response held until taken
          end else begin
            state <= tp.victim_dirty ? ST_EV_RD : ST_REFILL;
          end
        end
        ST_EV_RD:  state <= ST_EV_WR;
        ST_EV_WR: begin
          if (wb_fire) wb_cnt <= wb_cnt + offset_t'(1);
          if (wb_last && !fl_mode) state <= ST_REFILL;
        end
        ST_REFILL: begin
          if (rf_fire) rf_sent <= rf_sent + 1'b1;
          if (rf_recv_fire) rf_recv <= rf_recv + 1'b1;
          if (rf_last) state <= ST_REPLAY;
        end
        ST_REPLAY: state <= ST_LOOKUP;
        ST_FL_RD:  state <= ST_FL_CHK;
        ST_FL_CHK: begin
          if (tp.victim_dirty) state <= ST_EV_WR;
        end
        default:   state <= ST_IDLE;
      endcase
      // move the flush walk on, overriding the case above
      if (fl_adv) begin
        if (fl_last) begin
          fl_mode    <= 1'b0;
          flush_done <= flush;
          state      <= ST_IDLE;
        end else begin
          fl_idx <= fl_idx + index_t'(1);
          state  <= ST_FL_RD;
        end
      end
    end
  end

endmodule

/* cache_top.sv */
`timescale 1ns/1ps

module cache_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              flush,           // level, write back all dirty lines
  output logic              flush_done,
  // processor side
  input  logic              req_val,
  output logic              req_rdy,
  input  logic              req_write,
  input  cache_pkg::addr_t  req_addr,
  input  cache_pkg::word_t  req_wdata,
  output logic              resp_val,
  input  logic              resp_rdy,
  output cache_pkg::word_t  resp_rdata,
  // main memory side
  output logic              mem_req_val,
  input  logic              mem_req_rdy,
  output logic              mem_req_write,
  output cache_pkg::addr_t  mem_req_addr,
  output cache_pkg::word_t  mem_req_wdata,
  input  logic              mem_resp_val,
  output logic              mem_resp_rdy,
  input  cache_pkg::word_t  mem_resp_rdata
);

  tag_port_if  tp ();  // controller to tag store
  data_port_if dp ();  // controller to data store

  tag_store u_tag_store (
    .clk   (clk),
    .reset (reset),
    .tp    (tp.store)
  );

  data_store u_data_store (
    .clk (clk),
    .dp  (dp.store)
  );

  cache_ctrl u_ctrl (
    .clk            (clk),
    .reset          (reset),
    .flush          (flush),
    .flush_done     (flush_done),
    .req_val        (req_val),
    .req_write      (req_write),
    .req_addr       (req_addr),
    .req_wdata      (req_wdata),
    .req_rdy        (req_rdy),
    .resp_val       (resp_val),
    .resp_rdy       (resp_rdy),
    .resp_rdata     (resp_rdata),
    .mem_req_val    (mem_req_val),
    .mem_req_write  (mem_req_write),
    .mem_req_addr   (mem_req_addr),
    .mem_req_wdata  (mem_req_wdata),
    .mem_req_rdy    (mem_req_rdy),
    .mem_resp_val   (mem_resp_val),
    .mem_resp_rdy   (mem_resp_rdy),
    .mem_resp_rdata (mem_resp_rdata),
    .tp             (tp.ctrl),
    .dp             (dp.ctrl)
  );

endmodule

/* tb_main_mem.sv */
`timescale 1ns/1ps

module tb_main_mem (
  input  logic             clk,
  input  logic             reset,
  input  logic             req_val,
  output logic             req_rdy,
  input  logic             req_write,
  input  cache_pkg::addr_t req_addr,
  input  cache_pkg::word_t req_wdata,
  output logic             resp_val,
  input  logic             resp_rdy,
  output cache_pkg::word_t resp_rdata
);
  import cache_pkg::*;

  word_t       mem [65536];           // whole word address space
  word_t       rd_data_q [$];         // read data waiting to go back, oldest first
  int unsigned rd_due_q [$];          // cycle from which each read may return
  int unsigned cycle_cnt = 0;
  logic        rdy_q     = 1'b0;
  logic        val_q     = 1'b0;
  word_t       rdata_q   = '0;

  assign req_rdy    = rdy_q;
  assign resp_val   = val_q;
  assign resp_rdata = rdata_q;

  // fill pattern built from every address bit
  function automatic word_t seed_word(input addr_t a);
    return {a ^ 16'h5aa5, ~a};
  endfunction

  initial begin
    for (int i = 0; i < 65536; i++) begin
      mem[i] = seed_word(addr_t'(i));
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      rdy_q <= 1'b0;
      val_q <= 1'b0;
      cycle_cnt = 0;
      rd_data_q.delete();
      rd_due_q.delete();
    end else begin
      cycle_cnt = cycle_cnt + 1;
      if (val_q && resp_rdy) begin                        // oldest read taken at this edge
        void'(rd_data_q.pop_front());
        void'(rd_due_q.pop_front());
      end
      if (req_val && rdy_q) begin
        if (req_write) begin
          mem[req_addr] = req_wdata;                      // writes get no response
        end else begin
          rd_data_q.push_back(mem[req_addr]);
          rd_due_q.push_back(cycle_cnt + 1 + ($urandom % 4));  // 1 to 4 cycles later
        end
      end
      rdy_q <= (($urandom % 4) != 0);                     // stall about one cycle in four
      // only the front may go, so reads return in order
      if (rd_data_q.size() != 0 && rd_due_q[0] <= cycle_cnt) begin
        val_q   <= 1'b1;
        rdata_q <= rd_data_q[0];
      end else begin
        val_q <= 1'b0;
      end
    end
  end

endmodule

/* tb_cache.sv */
`timescale 1ns/1ps

module tb_cache;
  import cache_pkg::*;

  localparam int NUM_RANDOM     = 300;                     // soak phase requests
  localparam int NUM_DIRECTED   = 19;                      // all other requests
  localparam int FLUSH_CYCLES   = 16 * 50;                 // every line dirty, slow memory
  localparam int TIMEOUT_CYCLES = (NUM_RANDOM + NUM_DIRECTED) * 200 + FLUSH_CYCLES;

  // ==========================================================================
  // DUT signals and reference state
  // ==========================================================================

  logic  clk       = 1'b0;
  logic  reset     = 1'b1;
  logic  flush     = 1'b0;
  logic  flush_done;
  logic  req_val   = 1'b0;
  logic  req_rdy;
  logic  req_write = 1'b0;
  addr_t req_addr  = '0;
  word_t req_wdata = '0;
  logic  resp_val;
  logic  resp_rdy  = 1'b1;
  word_t resp_rdata;
  logic  mem_req_val, mem_req_rdy, mem_req_write;
  addr_t mem_req_addr;
  word_t mem_req_wdata;
  logic  mem_resp_val, mem_resp_rdy;
  word_t mem_resp_rdata;

  word_t       shadow [addr_t];                            // last value written per address
  word_t       exp_data_q [$];                             // expected responses, request order
  string       exp_name_q [$];
  int unsigned value_errors    = 0;
  int unsigned protocol_errors = 0;
  int unsigned cycle_cnt       = 0;
  int unsigned accept_cycle    = 0;
  int unsigned last_latency    = 0;                        // accept to first resp_val
  logic        waiting         = 1'b0;
  logic        stall_resp      = 1'b0;                     // random resp_rdy when set
  logic        held_val        = 1'b0;                     // response stalled at last edge
  word_t       held_data       = '0;
  addr_t       last_addr       = '0;

  always #5 clk = ~clk;                                    // 10 ns period

  cache_top UUT (.*);

  tb_main_mem u_mem (
    .clk        (clk),
    .reset      (reset),
    .req_val    (mem_req_val),
    .req_rdy    (mem_req_rdy),
    .req_write  (mem_req_write),
    .req_addr   (mem_req_addr),
    .req_wdata  (mem_req_wdata),
    .resp_val   (mem_resp_val),
    .resp_rdy   (mem_resp_rdy),
    .resp_rdata (mem_resp_rdata)
  );

  function automatic word_t seed_word(input addr_t a);
    return {a ^ 16'h5aa5, ~a};                             // same fill as the memory model
  endfunction

  function automatic word_t expected_word(input addr_t a);
    if (shadow.exists(a)) return shadow[a];
    return seed_word(a);                                   // never written
  endfunction

  task automatic compare_word(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      value_errors = value_errors + 1;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // drive one request and wait for its accept, the response is checked elsewhere
  task automatic send_request(input logic wr, input addr_t a, input word_t d, input string name);
    @(posedge clk);
    req_val   <= 1'b1;
    req_write <= wr;
    req_addr  <= a;
    req_wdata <= d;
    exp_data_q.push_back(wr ? word_t'(0) : expected_word(a));  // writes answer with zero
    exp_name_q.push_back(name);
    if (wr) shadow[a] = d;
    @(posedge clk);
    while (!(req_val && req_rdy)) begin
      @(posedge clk);
    end
    req_val <= 1'b0;
  endtask

  task automatic drain_responses();
    while (exp_data_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  // ==========================================================================
  // response checker
  // ==========================================================================

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (!reset) begin
      if (waiting && resp_val) begin                       // first resp_val after accept
        last_latency = cycle_cnt - accept_cycle;
        waiting      = 1'b0;
      end
      if (req_val && req_rdy) begin
        accept_cycle = cycle_cnt;
        waiting      = 1'b1;
      end
      if (held_val && !resp_val) begin
        protocol_errors = protocol_errors + 1;
        $display("resp_val dropped before the response was taken");
      end
      if (mem_resp_val && !mem_resp_rdy) begin            // only refills get responses
        protocol_errors = protocol_errors + 1;
        $display("memory read response refused during a refill");
      end
      if (held_val && resp_val) compare_word("resp_rdata hold", held_data, resp_rdata);
      held_val  = resp_val && !resp_rdy;
      held_data = resp_rdata;
      if (resp_val && resp_rdy) begin
        if (exp_data_q.size() == 0) begin
          protocol_errors = protocol_errors + 1;
          $display("response arrived with no request outstanding");
        end else begin
          compare_word(exp_name_q.pop_front(), exp_data_q.pop_front(), resp_rdata);
        end
      end
    end
  end

  always @(posedge clk) begin
    if (stall_resp) resp_rdy <= (($urandom % 3) != 0);
    else resp_rdy <= 1'b1;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    $display("Simulation failed");
    $finish;
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================

  initial begin
    void'($urandom(80062));
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    compare_word("reset req_rdy", 32'd1, 32'(req_rdy));
    compare_word("reset resp_val", 32'd0, 32'(resp_val));
    compare_word("reset mem_req_val", 32'd0, 32'(mem_req_val));
    compare_word("reset flush_done", 32'd0, 32'(flush_done));

    send_request(1'b0, 16'h0020, '0, "cold read");
    send_request(1'b0, 16'h0020, '0, "hit read");
    drain_responses();
    compare_word("hit latency", 32'd1, last_latency);

    send_request(1'b1, 16'h0105, 32'hcafe_0105, "line write");
    for (int i = 4; i < 8; i++) send_request(1'b0, addr_t'(16'h0100 + i), '0, "line read");

    // index 3 under tags 5, 9 and 13, each write evicts a dirty line
    send_request(1'b1, 16'h014c, 32'h1111_014c, "conflict write");
    send_request(1'b1, 16'h024d, 32'h2222_024d, "conflict write");
    send_request(1'b1, 16'h034e, 32'h3333_034e, "conflict write");
    send_request(1'b0, 16'h014c, '0, "conflict read");
    send_request(1'b0, 16'h024d, '0, "conflict read");
    send_request(1'b0, 16'h034e, '0, "conflict read");
    send_request(1'b0, 16'h014f, '0, "conflict read");
    drain_responses();

    stall_resp <= 1'b1;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      last_addr = addr_t'(32'h1000 + ($urandom % 192));   // three tags per index
      if (($urandom % 2) != 0) send_request(1'b1, last_addr, $urandom, "random write");
      else send_request(1'b0, last_addr, '0, "random read");
    end
    drain_responses();
    stall_resp <= 1'b0;

    flush <= 1'b1;
    @(posedge clk);
    while (!flush_done) begin
      @(posedge clk);
    end
    compare_word("req_rdy during flush", 32'd0, 32'(req_rdy));
    foreach (shadow[a]) compare_word("memory after flush", shadow[a], u_mem.mem[a]);
    flush <= 1'b0;
    @(posedge clk);
    compare_word("flush_done as flush drops", 32'd1, 32'(flush_done));
    @(posedge clk);
    compare_word("flush_done after flush drop", 32'd0, 32'(flush_done));

    // last touched line stays valid through the flush
    send_request(1'b0, last_addr, '0, "post-flush hit");
    drain_responses();
    compare_word("post-flush hit latency", 32'd1, last_latency);
    send_request(1'b0, 16'h0105, '0, "post-flush read");
    send_request(1'b0, 16'h014c, '0, "post-flush read");
    send_request(1'b0, 16'h024d, '0, "post-flush read");
    send_request(1'b0, 16'h034e, '0, "post-flush read");
    drain_responses();
    repeat (2) @(posedge clk);

    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+.
cache_pkg.sv
cache_ifs.sv
tag_store.sv
data_store.sv
cache_ctrl.sv
cache_top.sv
tb_main_mem.sv
tb_cache.sv

/* Makefile */
# Verilator build and run of the cache testbench

sim:
	verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_cache -f sim.f
	out=$$(./obj_dir/Vtb_cache); echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
